/* memIcTop.f */
+incdir+design
design/memIcPkg.sv
design/memIcGetOpLen.sv
design/memIcArbiter.sv
design/memIcRam.sv
design/memIcFetch.sv
design/memIcTop.sv
verif/memIcTop_sva.sv
verif/memIcTopTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = memIcTopTb
FILELIST = memIcTop.f
PASS_MSG = All tests passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* verif/memIcTopTb.sv */
`include "memIc_macros.svh"

module memIcTopTb;
	timeunit 1ns;
	timeprecision 100ps;
	import memIcPkg::*;

	localparam int NumTests = 8;
	localparam int AddrW = `MEMIC_ADDR_W;
	localparam logic [0:7][15:0] BaseHeads = {16'h0123, 16'h9000, 16'h7800, 16'hFE00,
		16'hE000, 16'hF200, 16'h3456, 16'hEE00};
	localparam logic [0:7][15:0] RvHeads = {16'h0013, 16'hFE01, 16'h4003, 16'h7802,
		16'hFFFF, 16'h0000, 16'h9003, 16'hEE10};
	localparam logic [0:7][15:0] MixHeads = {16'h7A00, 16'h0001, 16'hFC00, 16'h9800,
		16'h1111, 16'hE600, 16'hF000, 16'h0FFF};

	typedef struct packed {
		modeCfgT          mode;
		logic [AddrW-1:0] addr;
		logic [3:0]       count;	// Instructions taken before stop
		logic             reload;	// Load own program first
		logic             holdRand;
		logic             loadNext;	// Next row's program written during the run
		logic [0:7][15:0] heads;
	} testRowT;

	logic clock = 1'b0;
	logic arstN;
	logic loadStb;
	logic [AddrW-1:0] loadAddr;
	logic [15:0] loadData;
	logic start;
	logic stop;
	logic [AddrW-1:0] startAddr;
	logic hold;
	modeCfgT mode;
	logic istrValid;
	istrT istr;
	logic busy;

	testRowT rows [NumTests];
	string names [NumTests];
	logic [15:0] image [1 << AddrW];	// Mirror of RAM contents
	logic [AddrW-1:0] pendAddr [$];
	logic [15:0] pendData [$];
	istrT expQ [$];
	int cycles = 0;
	int limit = 1000000;
	int errors = 0;
	int failedTests = 0;

	memIcTop UUT (.*);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic opLenT refLen(logic [15:0] h, modeCfgT m);
		logic [2:0] sel;
		opLenT len;
		sel = h[11:9];
		if (`MEMIC_ENABLE_RV && m.isRV) begin
			return (h[1:0] == 2'b11) ? OP_LEN32 : OP_LEN16;
		end
		if (m.isXG2 || h[15:13] == 3'b111) begin
			if (h[12]) begin
				len = (sel == 3'b111) ? OP_LEN96 :
					(sel == 3'b110 || sel[2:1] == 2'b01) ? OP_LEN64 : OP_LEN32;
			end else begin
				len = (sel == 3'b111 || sel == 3'b101) ? OP_LEN64 : OP_LEN32;
			end
		end else if (h[15:12] == 4'b1001 || h[15:12] == 4'b0111) begin
			len = h[11] ? OP_LEN64 : OP_LEN32;
		end else begin
			len = OP_LEN16;
		end
		return len;
	endfunction

	function automatic int parcels(opLenT len);
		case (len)
			OP_LEN16: return 1;
			OP_LEN32: return 2;
			OP_LEN64: return 4;
			default:  return 6;
		endcase
	endfunction

	task automatic addRow(input int r, input string name, input modeCfgT m,
		input logic [AddrW-1:0] addr, input int count, input logic reload,
		input logic holdRand, input logic loadNext, input logic [0:7][15:0] heads);
		names[r] = name;
		rows[r] = '{mode: m, addr: addr, count: 4'(count), reload: reload,
			holdRand: holdRand, loadNext: loadNext, heads: heads};
	endtask

	// Head parcel followed by random tail parcels
	task automatic buildProgram(input testRowT row);
		logic [AddrW-1:0] a;
		int n;
		a = row.addr;
		for (int i = 0; i < 8; i++) begin
			n = parcels(refLen(row.heads[i], row.mode));
			for (int k = 0; k < n; k++) begin
				pendAddr.push_back(a);
				pendData.push_back((k == 0) ? row.heads[i] : 16'($urandom));
				a = a + AddrW'(1);
			end
		end
	endtask

	task automatic applyLoad();
		loadStb = 1'b1;
		loadAddr = pendAddr.pop_front();
		loadData = pendData.pop_front();
		image[loadAddr] = loadData;
	endtask

	task automatic flushLoads();
		while (pendAddr.size() > 0) begin
			applyLoad();
			@(posedge clock);
			#1;
		end
		loadStb = 1'b0;
	endtask

	task automatic makeExpected(input testRowT row);
		logic [AddrW-1:0] pc;
		istrT e;
		int n;
		expQ.delete();
		pc = row.addr;
		for (int i = 0; i < int'(row.count); i++) begin
			e.pc = pc;
			e.len = refLen(image[pc], row.mode);
			n = parcels(e.len);
			e.bits = '0;
			for (int k = 0; k < n; k++) begin
				e.bits[16*k +: 16] = image[pc + AddrW'(k)];
			end
			expQ.push_back(e);
			pc = pc + AddrW'(n);
		end
	endtask

	task automatic checkIstr(input string name, input int idx, input istrT exp);
		assert (istr.pc == exp.pc) else begin
			$display("[FAIL] %s #%0d pc: expected %h, actual %h", name, idx, exp.pc, istr.pc);
			errors++;
		end
		assert (istr.len == exp.len) else begin
			$display("[FAIL] %s #%0d len: expected %s, actual %s", name, idx,
				exp.len.name(), istr.len.name());
			errors++;
		end
		assert (istr.bits == exp.bits) else begin
			$display("[FAIL] %s #%0d bits: expected %h, actual %h", name, idx,
				exp.bits, istr.bits);
			errors++;
		end
	endtask

	task automatic runTest(input int r);
		testRowT row;
		int idx;
		int errBefore;
		logic toggle;
		row = rows[r];
		errBefore = errors;
		if (row.reload) begin
			buildProgram(row);
			flushLoads();
		end
		makeExpected(row);
		if (row.loadNext) begin
			buildProgram(rows[r + 1]);
		end
		mode = row.mode;
		startAddr = row.addr;
		start = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;
		idx = 0;
		toggle = 1'b0;
		while (idx < int'(row.count)) begin
			@(negedge clock);
			if (istrValid) begin
				checkIstr(names[r], idx, expQ[idx]);
				idx++;
			end
			@(posedge clock);
			#1;
			hold = row.holdRand ? 1'($urandom) : 1'b0;
			toggle = ~toggle;
			loadStb = 1'b0;
			if (toggle && pendAddr.size() > 0) begin
				applyLoad();	// Every other cycle so reads still get through
			end
		end
		hold = 1'b0;
		stop = 1'b1;
		@(posedge clock);
		#1;
		stop = 1'b0;
		loadStb = 1'b0;	// Last loader word lands with the stop edge
		for (int c = 0; c < 4 && busy; c++) begin
			@(negedge clock);
			assert (!istrValid) else begin
				$display("Instruction emitted after stop in test %s", names[r]);
				errors++;
			end
		end
		assert (!busy) else begin
			$display("Fetch still busy four cycles after stop in test %s", names[r]);
			errors++;
		end
		@(posedge clock);
		#1;
		flushLoads();
		failedTests += (errors != errBefore) ? 1 : 0;
		$display("Test %s done: %0d instructions, %0d errors", names[r], idx, errors - errBefore);
	endtask

	initial begin
		int total;
		void'($urandom(32'h329));
		arstN = 1'b0;
		loadStb = 1'b0;
		loadAddr = '0;
		loadData = '0;
		start = 1'b0;
		stop = 1'b0;
		startAddr = '0;
		hold = 1'b0;
		mode = '0;
		addRow(0, "base", 2'b00, 8'h00, 8, 1'b1, 1'b0, 1'b0, BaseHeads);
		addRow(1, "hold", 2'b00, 8'h00, 8, 1'b0, 1'b1, 1'b0, BaseHeads);
		addRow(2, "xg2", 2'b10, 8'h40, 8, 1'b1, 1'b0, 1'b0, BaseHeads);
		addRow(3, "riscv", 2'b01, 8'h80, 8, 1'b1, 1'b0, 1'b0, RvHeads);
		addRow(4, "arbiter", 2'b00, 8'h00, 8, 1'b0, 1'b0, 1'b1, BaseHeads);
		addRow(5, "readback", 2'b00, 8'hC0, 8, 1'b0, 1'b0, 1'b0, MixHeads);
		addRow(6, "stopMid", 2'b10, 8'h40, 3, 1'b0, 1'b1, 1'b0, BaseHeads);
		addRow(7, "restart", 2'b01, 8'h80, 8, 1'b0, 1'b0, 1'b0, RvHeads);
		total = 0;
		for (int r = 0; r < NumTests; r++) begin
			for (int i = 0; i < 8; i++) begin
				total += parcels(refLen(rows[r].heads[i], rows[r].mode));
			end
		end
		limit = total * 8 + 200;
		repeat (2) @(posedge clock);
		#1;
		arstN = 1'b1;
		for (int r = 0; r < NumTests; r++) begin
			runTest(r);
		end
		$display("Summary: %0d tests, %0d failed, %0d check errors", NumTests, failedTests,
			errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* verif/memIcTop_sva.sv */
`include "memIc_macros.svh"

module memIcTop_sva (
	input logic                                     clock,
	input logic                                     arstN,
	input logic                                     start,
	input logic                                     istrValid,
	input logic                                     hold,
	input logic                                     loadStb,
	input logic                                     rdGnt,
	input logic [`MEMIC_ADDR_W-1:0]                 rdAddr,
	input logic [`MEMIC_ADDR_W-1:0]                 pc,
	input logic [$clog2(`MEMIC_WIN_WORDS + 1)-1:0] fill,
	input memIcPkg::fetchStateT                     state
);
	timeunit 1ns;
	timeprecision 100ps;
	import memIcPkg::*;

	// Head pc only moves when an instruction leaves
	holdBlocksEmit: assert property (@(posedge clock) disable iff (!arstN)
		(hold && !start) |=> !$past(istrValid) && $stable(pc))
		else $error("Instruction emitted or pc moved while hold is high");

	fillInRange: assert property (@(posedge clock) disable iff (!arstN)
		int'(fill) <= `MEMIC_WIN_WORDS)
		else $error("Window fill count above window depth");

	// Loader owns the RAM port in its strobe cycle
	loaderWins: assert property (@(posedge clock) disable iff (!arstN)
		(loadStb && !start) |=> !$past(rdGnt) && $stable(rdAddr))
		else $error("Fetch read granted or read address advanced during a loader write");

	idleSilent: assert property (@(posedge clock) disable iff (!arstN)
		(state == FS_IDLE && !start) |=> (state == FS_IDLE) && !istrValid)
		else $error("Fetch left idle without start or emitted while idle");

endmodule

bind memIcTop memIcTop_sva uSva (
	.clock,
	.arstN,
	.start,
	.istrValid,
	.hold,
	.loadStb,
	.rdGnt,
	.rdAddr,
	.pc(istr.pc),
	.fill(uFetch.fill),
	.state(uFetch.state)
);

/* design/memIcTop.sv */
`include "memIc_macros.svh"

module memIcTop (
	input  logic                     clock,
	input  logic                     arstN,
	input  logic                     loadStb,
	input  logic [`MEMIC_ADDR_W-1:0] loadAddr,
	input  logic [15:0]              loadData,
	input  logic                     start,
	input  logic                     stop,
	input  logic [`MEMIC_ADDR_W-1:0] startAddr,
	input  logic                     hold,
	input  memIcPkg::modeCfgT        mode,
	output logic                     istrValid,
	output memIcPkg::istrT           istr,
	output logic                     busy
);
	import memIcPkg::*;

	memReqT memReq;
	logic rdReq;
	logic rdGnt;
	logic [`MEMIC_ADDR_W-1:0] rdAddr;
	logic [15:0] rdData;
	logic [15:0] headBits;
	opLenT opLen;

	memIcArbiter uArb (
		.loadStb, .loadAddr, .loadData, .rdReq, .rdAddr, .rdGnt, .memReq
	);

	memIcRam uRam (
		.clock, .memReq, .rdData
	);

	memIcFetch uFetch (
		.clock, .arstN, .start, .stop, .startAddr, .hold, .mode,
		.rdGnt, .rdData, .rdReq, .rdAddr, .headBits, .opLen,
		.istrValid, .istr, .busy
	);

	// Decoder sees the window head in the same cycle
	memIcGetOpLen uDecode (
		.istrBits(headBits),
		.mode,
		.opLen
	);

endmodule

/* design/memIcFetch.sv */
`include "memIc_macros.svh"

module memIcFetch (
	input  logic                     clock,
	input  logic                     arstN,
	input  logic                     start,	// Clears window, enters run
	input  logic                     stop,
	input  logic [`MEMIC_ADDR_W-1:0] startAddr,
	input  logic                     hold,	// Blocks emission
	input  memIcPkg::modeCfgT        mode,
	input  logic                     rdGnt,
	input  logic [15:0]              rdData,
	output logic                     rdReq,
	output logic [`MEMIC_ADDR_W-1:0] rdAddr,
	output logic [15:0]              headBits,	// To length decoder
	input  memIcPkg::opLenT          opLen,
	output logic                     istrValid,
	output memIcPkg::istrT           istr,
	output logic                     busy
);
	import memIcPkg::*;

	localparam int AddrW   = `MEMIC_ADDR_W;
	localparam int WinBits = 16 * `MEMIC_WIN_WORDS;
	localparam int CntW    = $clog2(`MEMIC_WIN_WORDS + 1);

	fetchStateT state;
	modeCfgT modeQ;	// Mode the run began with
	logic inFlight;	// Grant last cycle, data now
	logic [`MEMIC_WIN_WORDS-1:0][15:0] win;
	logic [CntW-1:0] fill;
	logic [AddrW-1:0] pcQ;	// Address of win[0]

	logic [CntW-1:0] need;
	logic [CntW-1:0] take;
	logic [CntW-1:0] fillKept;
	logic [CntW:0] occupied;
	logic arrive;
	logic [`MEMIC_WIN_WORDS-1:0][15:0] winNext;

	always_comb begin
		case (opLen)
			OP_LEN16: need = CntW'(1);
			OP_LEN32: need = CntW'(2);
			OP_LEN64: need = CntW'(4);
			default:  need = CntW'(6);
		endcase
	end

	assign headBits = win[0];
	assign busy     = (state != FS_IDLE);

	// Held words plus the one on its way
	assign occupied = {1'b0, fill} + {{CntW{1'b0}}, inFlight};
	assign rdReq    = (state == FS_RUN) && (occupied < (CntW + 1)'(`MEMIC_WIN_WORDS));

	// Decode only under the mode the run began with
	assign istrValid = (state == FS_RUN) && !hold && (mode == modeQ) && (fill >= need);

	assign istr.pc   = pcQ;
	assign istr.len  = opLen;
	assign istr.bits = win & ({WinBits{1'b1}} >> (16 * (`MEMIC_WIN_WORDS - need)));

	assign take     = istrValid ? need : '0;
	assign fillKept = fill - take;
	assign arrive   = (state == FS_RUN) && inFlight;

	always_comb begin
		winNext = win >> (16 * take);
		if (arrive) begin
			winNext[fillKept] = rdData;	// Append behind kept parcels
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state    <= FS_IDLE;
			modeQ    <= '0;
			inFlight <= 1'b0;
			fill     <= '0;
			rdAddr   <= '0;
			pcQ      <= '0;
		end else if (start) begin
			state    <= FS_RUN;
			modeQ    <= mode;
			inFlight <= 1'b0;	// Old read is dropped
			fill     <= '0;
			rdAddr   <= startAddr;
			pcQ      <= startAddr;
		end else begin
			inFlight <= rdGnt;
			if (rdGnt) begin
				rdAddr <= rdAddr + AddrW'(1);
			end
			case (state)
				FS_RUN: begin
					fill <= fillKept + CntW'(arrive);
					if (istrValid) begin
						pcQ <= pcQ + AddrW'(need);
					end
					if (stop) begin
						state <= FS_DRAIN;
					end
				end
				FS_DRAIN: begin
					fill <= '0;
					if (!inFlight) begin
						state <= FS_IDLE;	// Last word discarded
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			win <= '0;
		end else if (state == FS_RUN) begin
			win <= winNext;
		end
	end

endmodule

/* design/memIcRam.sv */
`include "memIc_macros.svh"

module memIcRam (
	input  logic             clock,
	input  memIcPkg::memReqT memReq,
	output logic [15:0]      rdData	// Valid the cycle after a read
);

	logic [15:0] mem [1 << `MEMIC_ADDR_W];

	always_ff @(posedge clock) begin
		if (memReq.en) begin
			if (memReq.wr) begin
				mem[memReq.addr] <= memReq.wdata;
			end else begin
				rdData <= mem[memReq.addr];
			end
		end
	end

endmodule

/* design/memIcArbiter.sv */
`include "memIc_macros.svh"

module memIcArbiter (
	input  logic                     loadStb,	// One word per pulse
	input  logic [`MEMIC_ADDR_W-1:0] loadAddr,
	input  logic [15:0]              loadData,
	input  logic                     rdReq,	// Level from fetch
	input  logic [`MEMIC_ADDR_W-1:0] rdAddr,
	output logic                     rdGnt,
	output memIcPkg::memReqT         memReq
);

	// Loader has fixed priority, fetch only waits a cycle
	always_comb begin
		memReq = '0;
		rdGnt  = 1'b0;
		if (loadStb) begin
			memReq.en    = 1'b1;
			memReq.wr    = 1'b1;
			memReq.addr  = loadAddr;
			memReq.wdata = loadData;
		end else if (rdReq) begin
			memReq.en   = 1'b1;
			memReq.wr   = 1'b0;
			memReq.addr = rdAddr;
			rdGnt       = 1'b1;	// Fetch samples rdAddr now
		end
	end

endmodule

/* design/memIcGetOpLen.sv */
`include "memIc_macros.svh"

module memIcGetOpLen (
	input  logic [15:0]       istrBits,	// Head parcel
	input  memIcPkg::modeCfgT mode,
	output memIcPkg::opLenT   opLen
);
	import memIcPkg::*;

	opLenT lenHi;	// Table for bit 12 set
	opLenT lenLo;	// Table for bit 12 clear
	opLenT lenSel;

	always_comb begin
		casez (istrBits[11:9])
			3'b111:  lenHi = OP_LEN96;
			3'b110:  lenHi = OP_LEN64;
			3'b10?:  lenHi = OP_LEN32;
			3'b01?:  lenHi = OP_LEN64;
			default: lenHi = OP_LEN32;	// 00x
		endcase
	end

	always_comb begin
		casez (istrBits[11:9])
			3'b111:  lenLo = OP_LEN64;
			3'b110:  lenLo = OP_LEN32;
			3'b101:  lenLo = OP_LEN64;
			3'b100:  lenLo = OP_LEN32;
			default: lenLo = OP_LEN32;	// 0xx
		endcase
	end

	assign lenSel = istrBits[12] ? lenHi : lenLo;

	always_comb begin
		if (mode.isXG2) begin
			opLen = lenSel;	// Group bits ignored
		end else begin
			case (istrBits[15:12])
				4'b1111, 4'b1110: opLen = lenSel;
				4'b1001, 4'b0111: opLen = istrBits[11] ? OP_LEN64 : OP_LEN32;
				default:          opLen = OP_LEN16;
			endcase
		end

		// RISC-V compressed vs full width, wins over everything
		if (`MEMIC_ENABLE_RV && mode.isRV) begin
			if (istrBits[1:0] == 2'b11) begin
				opLen = OP_LEN32;
			end else begin
				opLen = OP_LEN16;
			end
		end
	end

endmodule

/* design/memIcPkg.sv */
`include "memIc_macros.svh"

package memIcPkg;

	// Length code, one bit per extra parcel group
	typedef enum logic [3:0] {
		OP_LEN16 = 4'b0001,	// One parcel
		OP_LEN32 = 4'b0010,	// Two parcels
		OP_LEN64 = 4'b0110,	// Four parcels
		OP_LEN96 = 4'b1110	// Six parcels
	} opLenT;

	typedef enum logic [1:0] {
		FS_IDLE,
		FS_RUN,
		FS_DRAIN
	} fetchStateT;

	typedef struct packed {
		logic isXG2;
		logic isRV;
	} modeCfgT;

	typedef struct packed {
		logic                     en;
		logic                     wr;	// Set for loader writes
		logic [`MEMIC_ADDR_W-1:0] addr;
		logic [15:0]              wdata;
	} memReqT;

	typedef struct packed {
		logic [`MEMIC_ADDR_W-1:0] pc;	// Address of first parcel
		opLenT                    len;
		logic [95:0]              bits;	// First parcel in low 16 bits
	} istrT;

endpackage

/* design/memIc_macros.svh */
`ifndef MEMIC_MACROS_SVH
`define MEMIC_MACROS_SVH

// Word address width of the instruction RAM
`define MEMIC_ADDR_W 8

// Parcel window depth, also the longest instruction
`define MEMIC_WIN_WORDS 6

// RISC-V length override in the decoder, 1'b0 compiles it away
`define MEMIC_ENABLE_RV 1'b1

`endif
